// ==== fxp_config.svh ====
// Fixed-point unit configuration
`ifndef FXP_CONFIG_SVH
`define FXP_CONFIG_SVH

// Word width of operands and results
`define FXP_WIDTH 32

// Fraction bits, Q16.16 by default
`define FXP_FRAC 16

// Restoring divider steps, one per quotient bit of left*2^FRAC
`define FXP_DIV_ITER (`FXP_WIDTH + `FXP_FRAC)

// Extra cycles per request allowed by the watchdog
`define FXP_WDOG_MARGIN 10

`endif

// ==== fxp_pkg.sv ====
// Fixed-point unit types
`include "fxp_config.svh"

package fxp_pkg;

  typedef enum logic [0:0] {
    OP_MUL = 1'b0,
    OP_DIV = 1'b1
  } fxp_op_e;

  typedef enum logic [1:0] {
    DIV_IDLE = 2'd0,
    DIV_RUN  = 2'd1,
    DIV_FIX  = 2'd2  // Sign correction of the quotient
  } div_state_e;

  typedef struct packed {
    fxp_op_e                op;
    logic                   is_signed;
    logic [`FXP_WIDTH-1:0]  left;
    logic [`FXP_WIDTH-1:0]  right;
  } fxp_req_t;

  typedef struct packed {
    fxp_op_e                op;      // Unit that produced the result
    logic [`FXP_WIDTH-1:0]  result;
  } fxp_resp_t;

endpackage

// ==== fxp_mult_pipe.sv ====
// Pipelined fixed-point multiplier
`timescale 1ns/1ps
`include "fxp_config.svh"

module fxp_mult_pipe
  import fxp_pkg::*;
(
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  start,
  input  fxp_req_t              req,
  output logic [`FXP_WIDTH-1:0] result,
  output logic                  done
);

  localparam int W = `FXP_WIDTH;
  localparam int F = `FXP_FRAC;

  logic             v1;
  logic             v2;
  logic [W-1:0]     a1;
  logic [W-1:0]     b1;
  logic             sgn1;
  logic [2*W-1:0]   a_ext;
  logic [2*W-1:0]   b_ext;
  logic [2*W-1:0]   prod2;

  // Zero extension for unsigned, sign extension for signed
  assign a_ext = {{W{sgn1 & a1[W-1]}}, a1};
  assign b_ext = {{W{sgn1 & b1[W-1]}}, b1};

  // Valid bits follow each product through the stages
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      v1   <= 1'b0;
      v2   <= 1'b0;
      done <= 1'b0;
    end else begin
      v1   <= start;
      v2   <= v1;
      done <= v2;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin  // Stage 1
      a1   <= req.left;
      b1   <= req.right;
      sgn1 <= req.is_signed;
    end
    if (v1) begin
      prod2 <= a_ext * b_ext;  // Low 2W bits are exact in both modes
    end
    if (v2) begin
      result <= prod2[W+F-1:F];
    end
  end

endmodule

// ==== fxp_div_seq.sv ====
// Iterative restoring fixed-point divider
`timescale 1ns/1ps
`include "fxp_config.svh"

module fxp_div_seq
  import fxp_pkg::*;
(
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  start,
  input  fxp_req_t              req,
  output logic [`FXP_WIDTH-1:0] result,
  output logic                  done
);

  localparam int W     = `FXP_WIDTH;
  localparam int F     = `FXP_FRAC;
  localparam int DW    = W + F;
  localparam int ITER  = `FXP_DIV_ITER;
  localparam int CNT_W = $clog2(ITER);

  div_state_e        state;
  logic [CNT_W-1:0]  cnt;

  logic              neg;   // Quotient must be negated
  logic [DW-1:0]     dvd;   // Dividend, consumed msb first
  logic [W-1:0]      rem;
  logic [W-1:0]      den;
  logic [W-1:0]      quo;

  logic [W-1:0]      left_mag;
  logic [W-1:0]      right_mag;
  logic [W:0]        rem_sh;
  logic [W:0]        diff;
  logic              fits;
  logic [W-1:0]      rem_next;
  logic [W-1:0]      quo_next;

  // Magnitudes only matter for signed requests
  always_comb begin
    left_mag  = req.left;
    right_mag = req.right;
    if (req.is_signed && req.left[W-1]) begin
      left_mag = -req.left;
    end
    if (req.is_signed && req.right[W-1]) begin
      right_mag = -req.right;
    end
  end

  // One shift-subtract step
  always_comb begin
    rem_sh   = {rem, dvd[DW-1]};
    diff     = rem_sh - {1'b0, den};
    fits     = (rem_sh >= {1'b0, den});  // Always true for a zero divisor
    rem_next = fits ? diff[W-1:0] : rem_sh[W-1:0];
    quo_next = {quo[W-2:0], fits};
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= DIV_IDLE;
      cnt   <= '0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        DIV_IDLE: begin
          if (start) begin
            state <= DIV_RUN;
            cnt   <= '0;
          end
        end
        DIV_RUN: begin
          cnt <= cnt + 1'b1;
          if (cnt == CNT_W'(ITER - 1)) begin
            state <= DIV_FIX;
          end
        end
        DIV_FIX: begin
          done  <= 1'b1;
          state <= DIV_IDLE;
        end
        default: state <= DIV_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == DIV_IDLE && start) begin
      neg <= req.is_signed & (req.left[W-1] ^ req.right[W-1]);
      dvd <= DW'(left_mag) << F;  // left * 2^FRAC
      den <= right_mag;
      rem <= '0;
      quo <= '0;
    end else if (state == DIV_RUN) begin
      dvd <= dvd << 1;
      rem <= rem_next;
      quo <= quo_next;  // Upper quotient bits fall off the top
    end else if (state == DIV_FIX) begin
      result <= neg ? -quo : quo;
    end
  end

endmodule

// ==== fxp_issue_ctrl.sv ====
// Request issue and result merge
`timescale 1ns/1ps
`include "fxp_config.svh"

module fxp_issue_ctrl
  import fxp_pkg::*;
(
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  go,
  input  fxp_req_t              req,
  input  logic [`FXP_WIDTH-1:0] mul_result,
  input  logic                  mul_done,
  input  logic [`FXP_WIDTH-1:0] div_result,
  input  logic                  div_done,
  output logic                  mul_start,
  output logic                  div_start,
  output fxp_req_t              unit_req,
  output fxp_resp_t             resp,
  output logic                  done,
  output logic                  busy
);

  logic accept;
  logic is_mul;

  // Any go during a divide is dropped
  assign accept = go & ~busy;
  assign is_mul = (req.op == OP_MUL);

  // Starts go out in the accepting cycle so the multiply keeps its latency
  assign mul_start = accept & is_mul;
  assign div_start = accept & ~is_mul;
  assign unit_req  = req;

  // Busy covers a divide from acceptance to its response
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy <= 1'b0;
    end else if (div_start) begin
      busy <= 1'b1;
    end else if (div_done) begin
      busy <= 1'b0;
    end
  end

  // Unit done pulses never coincide, so a plain priority mux is enough
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      done <= 1'b0;
      resp <= '0;
    end else begin
      done <= mul_done | div_done;
      if (mul_done) begin
        resp.op     <= OP_MUL;
        resp.result <= mul_result;
      end else if (div_done) begin
        resp.op     <= OP_DIV;
        resp.result <= div_result;
      end
    end
  end

endmodule

// ==== fxp_arith_unit.sv ====
// Fixed-point arithmetic unit top
`timescale 1ns/1ps
`include "fxp_config.svh"

module fxp_arith_unit
  import fxp_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  input  logic      go,
  input  fxp_req_t  req,
  output fxp_resp_t resp,
  output logic      done,
  output logic      busy
);

  logic                  mul_start;
  logic                  div_start;
  fxp_req_t              unit_req;
  logic [`FXP_WIDTH-1:0] mul_result;
  logic                  mul_done;
  logic [`FXP_WIDTH-1:0] div_result;
  logic                  div_done;

  fxp_issue_ctrl u_issue (
    .clk        (clk),
    .arst_n     (arst_n),
    .go         (go),
    .req        (req),
    .mul_result (mul_result),
    .mul_done   (mul_done),
    .div_result (div_result),
    .div_done   (div_done),
    .mul_start  (mul_start),
    .div_start  (div_start),
    .unit_req   (unit_req),
    .resp       (resp),
    .done       (done),
    .busy       (busy)
  );

  fxp_mult_pipe u_mult (
    .clk    (clk),
    .arst_n (arst_n),
    .start  (mul_start),
    .req    (unit_req),
    .result (mul_result),
    .done   (mul_done)
  );

  fxp_div_seq u_div (
    .clk    (clk),
    .arst_n (arst_n),
    .start  (div_start),
    .req    (unit_req),
    .result (div_result),
    .done   (div_done)
  );

endmodule

// ==== fxp_arith_unit_sva.sv ====
// Fixed-point unit assertions
`timescale 1ns/1ps
`include "fxp_config.svh"

module fxp_arith_unit_sva
  import fxp_pkg::*;
(
  input logic      clk,
  input logic      arst_n,
  input logic      go,
  input fxp_req_t  req,
  input fxp_resp_t resp,
  input logic      done,
  input logic      busy,
  input logic      mul_start,
  input logic      mul_done,
  input logic      div_done
);

  int unsigned fail_count = 0;
  int unsigned busy_cycles;

  // Length of the current divide, for the latency bound
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy_cycles <= 0;
    end else if (busy) begin
      busy_cycles <= busy_cycles + 1;
    end else begin
      busy_cycles <= 0;
    end
  end

  a_reset_quiet: assert property (@(posedge clk)
    !arst_n |=> (!done && !busy && resp == '0 && !mul_done && !div_done))
    else begin
      $error("Outputs not cleared by reset");
      fail_count++;
    end

  a_mul_latency: assert property (@(posedge clk) disable iff (!arst_n)
    (go && !busy && req.op == OP_MUL) |-> ##4 (done && resp.op == OP_MUL))
    else begin
      $error("Multiply response not 4 cycles after acceptance");
      fail_count++;
    end

  a_mul_unit: assert property (@(posedge clk) disable iff (!arst_n)
    mul_start |-> ##3 mul_done)
    else begin
      $error("Multiplier done not 3 cycles after start");
      fail_count++;
    end

  a_busy_rise: assert property (@(posedge clk) disable iff (!arst_n)
    (go && !busy && req.op == OP_DIV) |=> busy)
    else begin
      $error("Busy did not rise on divide acceptance");
      fail_count++;
    end

  a_busy_fall: assert property (@(posedge clk) disable iff (!arst_n)
    $fell(busy) |-> (done && resp.op == OP_DIV))
    else begin
      $error("Busy fell without a divide response");
      fail_count++;
    end

  a_div_done: assert property (@(posedge clk) disable iff (!arst_n)
    (done && resp.op == OP_DIV) |-> $fell(busy))
    else begin
      $error("Divide response while busy did not end");
      fail_count++;
    end

  a_div_bound: assert property (@(posedge clk) disable iff (!arst_n)
    busy |-> busy_cycles <= `FXP_DIV_ITER + 4)
    else begin
      $error("Divide exceeded its latency bound");
      fail_count++;
    end

  a_no_collide: assert property (@(posedge clk) disable iff (!arst_n)
    !(mul_done && div_done))
    else begin
      $error("Both units finished in the same cycle");
      fail_count++;
    end

endmodule

bind fxp_arith_unit fxp_arith_unit_sva u_sva (
  .clk       (clk),
  .arst_n    (arst_n),
  .go        (go),
  .req       (req),
  .resp      (resp),
  .done      (done),
  .busy      (busy),
  .mul_start (mul_start),
  .mul_done  (mul_done),
  .div_done  (div_done)
);

// ==== tb_fxp_arith_unit.sv ====
// Fixed-point unit testbench
`timescale 1ns/1ps
`include "fxp_config.svh"

module tb_fxp_arith_unit
  import fxp_pkg::*;
;

  localparam int W       = `FXP_WIDTH;
  localparam int F       = `FXP_FRAC;
  localparam int N_MUL   = 32;
  localparam int N_B2B   = 8;
  localparam int N_DIV   = 24;
  localparam int N_DZ    = 4;
  localparam int N_IGN   = 4;
  localparam int N_REQ   = N_MUL + N_B2B + N_DIV + N_DZ + N_IGN;
  localparam int PER_REQ = `FXP_DIV_ITER + `FXP_WDOG_MARGIN;

  logic      clk;
  logic      arst_n;
  logic      go;
  fxp_req_t  req;
  fxp_resp_t resp;
  logic      done;
  logic      busy;

  fxp_resp_t   exp_q[$];
  fxp_resp_t   expv;
  logic [31:0] lcg_state = 32'hf8c8_8b8b;
  int          n_err = 0;
  int          n_done = 0;
  int          n_accepted = 0;

  fxp_arith_unit u_dut (
    .clk    (clk),
    .arst_n (arst_n),
    .go     (go),
    .req    (req),
    .resp   (resp),
    .done   (done),
    .busy   (busy)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Product scaled back by 2^FRAC, low word kept
  function automatic logic [W-1:0] mul_model(input logic sgn, input logic [W-1:0] a,
                                             input logic [W-1:0] b);
    logic signed [2*W-1:0] sa;
    logic signed [2*W-1:0] sb;
    logic [2*W-1:0]        p;
    if (sgn) begin
      sa = $signed(a);
      sb = $signed(b);
      p  = sa * sb;
    end else begin
      p = {{W{1'b0}}, a} * {{W{1'b0}}, b};
    end
    return p[W+F-1:F];
  endfunction

  function automatic logic [W-1:0] div_model(input logic sgn, input logic [W-1:0] a,
                                             input logic [W-1:0] b);
    logic           neg;
    logic [W-1:0]   am;
    logic [W-1:0]   bm;
    logic [W-1:0]   q;
    logic [2*W-1:0] num;
    neg = sgn && (a[W-1] != b[W-1]);
    am  = (sgn && a[W-1]) ? -a : a;
    bm  = (sgn && b[W-1]) ? -b : b;
    num = {{W{1'b0}}, am} << F;
    if (bm == '0) begin
      q = '1;  // Divide by zero saturates the magnitude
    end else begin
      q = W'(num / {{W{1'b0}}, bm});
    end
    return neg ? -q : q;
  endfunction

  // Drives one request for a cycle, entered just after a falling edge
  task automatic send(input fxp_op_e op, input logic sgn, input logic [W-1:0] a,
                      input logic [W-1:0] b);
    fxp_resp_t e;
    go            = 1'b1;
    req.op        = op;
    req.is_signed = sgn;
    req.left      = a;
    req.right     = b;
    if (!busy) begin
      e.op     = op;
      e.result = (op == OP_MUL) ? mul_model(sgn, a, b) : div_model(sgn, a, b);
      exp_q.push_back(e);
      n_accepted++;
    end
    @(negedge clk);
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    go     = 1'b0;
    while ((exp_q.size() != 0 || busy) && waited < PER_REQ) begin
      @(negedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("Response missing after %0d cycles", waited);
      n_err++;
    end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge clk) begin
    if (arst_n && done) begin
      n_done++;
      if (exp_q.size() == 0) begin
        $display("Done pulse with no request outstanding");
        n_err++;
      end else begin
        expv = exp_q.pop_front();
        assert (resp == expv) else begin
          $display("Error: resp.result got %h expected %h, resp.op got %h expected %h",
                   resp.result, expv.result, resp.op, expv.op);
          n_err++;
        end
      end
    end
  end

  initial begin
    repeat (N_REQ * PER_REQ + 40) @(posedge clk);
    $display("Run timed out before all requests completed");
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    logic [W-1:0] am;
    logic [W-1:0] bm;
    arst_n = 1'b0;
    go     = 1'b0;
    req    = '0;
    repeat (10) @(negedge clk);
    arst_n = 1'b1;
    repeat (3) @(negedge clk);

    for (int i = 0; i < N_MUL; i++) begin
      send(OP_MUL, i[0], next_rand(), next_rand());
      drain();
    end

    for (int i = 0; i < N_B2B; i++) begin  // One request per cycle
      send(OP_MUL, i[1], next_rand(), next_rand());
    end
    drain();

    // Sign combinations from the loop index
    for (int i = 0; i < N_DIV; i++) begin
      am = next_rand() >> 12;
      bm = (next_rand() >> (8 + next_rand() % 16)) | 32'd1;
      if (i[0]) begin
        send(OP_DIV, 1'b1, i[1] ? -am : am, i[2] ? -bm : bm);
      end else begin
        send(OP_DIV, 1'b0, next_rand(), bm);
      end
      drain();
    end

    send(OP_DIV, 1'b0, next_rand(), '0);
    drain();
    send(OP_DIV, 1'b1, 32'h0003_8000, '0);
    drain();
    send(OP_DIV, 1'b1, 32'hfffc_8000, '0);
    drain();
    send(OP_DIV, 1'b0, 32'h8000_0000, '0);
    drain();

    send(OP_DIV, 1'b1, 32'h0010_0000, 32'hfffd_0000);
    for (int i = 1; busy; i++) begin  // Dropped while busy, one per cycle
      send(i[0] ? OP_MUL : OP_DIV, 1'b0, next_rand(), next_rand());
    end
    drain();
    repeat (8) @(negedge clk);

    assert (n_done == n_accepted) else begin
      $display("Saw %0d done pulses for %0d accepted requests", n_done, n_accepted);
      n_err++;
    end
    $display("Summary: %0d check errors, %0d assertion failures, %0d responses",
             n_err, u_dut.u_sva.fail_count, n_done);
    if (n_err == 0 && u_dut.u_sva.fail_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+.
fxp_pkg.sv
fxp_mult_pipe.sv
fxp_div_seq.sv
fxp_issue_ctrl.sv
fxp_arith_unit.sv
fxp_arith_unit_sva.sv
tb_fxp_arith_unit.sv

// ==== run.sh ====
#!/bin/sh
# Verilator build and run of the fixed-point unit testbench
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module tb_fxp_arith_unit -f all.f -o sim_fxp &&
./obj_dir/sim_fxp +verilator+error+limit+1000 | tee /dev/stderr | grep -q "NO ERRORS" &&
echo "Simulation passed" ||
{
  echo "Simulation failed"
  exit 1
}
